/* common/boxsum_pkg.sv */
package boxsum_pkg;

  // one channel of a pixel beat
  localparam int PIX_W = 8;

  // horizontal window length; the lane datapath is built around it
  localparam int WIN = 8;

  // WIN full-scale pixels, 8 * 255 = 2040, fit in 11 bits
  localparam int SUM_W = PIX_W + 3;

  // row sequencer states
  typedef enum logic [2:0] {
    S_IDLE   = 3'd0,
    S_START  = 3'd1,
    S_ROW    = 3'd2,
    S_FILL   = 3'd3,
    S_SLIDE  = 3'd4,
    S_FINISH = 3'd5
  } ctrl_state_e;

endpackage

/* lane/window_lane.sv */
`timescale 1ns/1ps

module window_lane (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic [boxsum_pkg::PIX_W-1:0] pix,
  input  logic                        shift,
  input  logic                        clr,
  input  logic                        emit,
  output logic [boxsum_pkg::SUM_W-1:0] sum,
  output logic                        sum_valid
);

  localparam int PIX_W = boxsum_pkg::PIX_W;
  localparam int SUM_W = boxsum_pkg::SUM_W;
  localparam int WIN   = boxsum_pkg::WIN;

  logic [PIX_W-1:0] hist [WIN];
  logic [SUM_W-1:0] acc;
  logic [SUM_W-1:0] acc_nxt;

  // oldest pixel drops out as the new one comes in
  assign acc_nxt = clr ? SUM_W'(pix) : acc + SUM_W'(pix) - SUM_W'(hist[WIN-1]);

  always_ff @(posedge clk) begin
    if (shift) begin
      for (int k = WIN - 1; k > 0; k--) begin
        hist[k] <= clr ? '0 : hist[k-1];
      end
      hist[0] <= pix;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc <= '0;
    end else if (shift) begin
      acc <= acc_nxt;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sum_valid <= 1'b0;
    end else begin
      sum_valid <= emit;
    end
  end

  always_ff @(posedge clk) begin
    if (emit) begin
      sum <= acc_nxt;
    end
  end

endmodule

/* rtl/beat_feeder.sv */
`timescale 1ns/1ps

module beat_feeder #(
  parameter int LANES      = 4,
  parameter int FEED_DEPTH = 4
) (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic                                   in_valid,
  input  logic [LANES*boxsum_pkg::PIX_W-1:0]     in_data,
  input  logic                                   pop,
  output logic [LANES*boxsum_pkg::PIX_W-1:0]     head_data,
  output logic [$clog2(FEED_DEPTH+1)-1:0]        feed_level,
  output logic                                   in_credit
);

  localparam int DATA_W = LANES * boxsum_pkg::PIX_W;
  localparam int PTR_W  = (FEED_DEPTH > 1) ? $clog2(FEED_DEPTH) : 1;

  logic [DATA_W-1:0] mem [FEED_DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(FEED_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign head_data = mem[rd_ptr];

  // sender holds a credit for every write, so no full check here
  always_ff @(posedge clk) begin
    if (in_valid) begin
      mem[wr_ptr] <= in_data;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      feed_level <= '0;
      in_credit  <= 1'b0;
    end else begin
      in_credit <= pop;
      if (in_valid) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({in_valid, pop})
        2'b10:   feed_level <= feed_level + 1'b1;
        2'b01:   feed_level <= feed_level - 1'b1;
        default: feed_level <= feed_level;
      endcase
    end
  end

endmodule

/* rtl/row_ctrl.sv */
`timescale 1ns/1ps

module row_ctrl #(
  parameter int COLS  = 12,
  parameter int ROWS  = 3,
  parameter int LVL_W = 3
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             start,
  input  logic [LVL_W-1:0] feed_level,
  input  logic             room,
  output logic             pop,
  output logic             clr,
  output logic             shift,
  output logic             emit,
  output logic             busy,
  output logic             frame_done
);

  localparam int COL_W = $clog2(COLS + 1);
  localparam int ROW_W = $clog2(ROWS + 1);

  boxsum_pkg::ctrl_state_e state;
  boxsum_pkg::ctrl_state_e state_nxt;
  logic [COL_W-1:0]        col;
  logic [ROW_W-1:0]        row;
  logic                    have_pix;
  logic                    fill_done;
  logic                    col_last;
  logic                    row_last;

  // col counts pixels already popped in the current row
  assign have_pix  = (feed_level != '0);
  assign fill_done = (col == COL_W'(boxsum_pkg::WIN - 2));
  assign col_last  = (col == COL_W'(COLS - 1));
  assign row_last  = (row == ROW_W'(ROWS - 1));

  always_comb begin
    case (state)
      boxsum_pkg::S_ROW,
      boxsum_pkg::S_FILL:  pop = have_pix;
      boxsum_pkg::S_SLIDE: pop = have_pix & room;
      default:             pop = 1'b0;
    endcase
  end

  assign shift      = pop;
  assign clr        = pop & (state == boxsum_pkg::S_ROW);
  assign emit       = pop & (state == boxsum_pkg::S_SLIDE);
  assign busy       = (state != boxsum_pkg::S_IDLE);
  assign frame_done = (state == boxsum_pkg::S_FINISH);

  always_comb begin
    state_nxt = state;
    case (state)
      boxsum_pkg::S_IDLE:   if (start) state_nxt = boxsum_pkg::S_START;
      // two beats queued before the first pop of the frame
      boxsum_pkg::S_START:  if (feed_level >= LVL_W'(2)) state_nxt = boxsum_pkg::S_ROW;
      boxsum_pkg::S_ROW:    if (pop) state_nxt = boxsum_pkg::S_FILL;
      boxsum_pkg::S_FILL:   if (pop && fill_done) state_nxt = boxsum_pkg::S_SLIDE;
      boxsum_pkg::S_SLIDE: begin
        if (pop && col_last) begin
          state_nxt = row_last ? boxsum_pkg::S_FINISH : boxsum_pkg::S_ROW;
        end
      end
      default:              state_nxt = boxsum_pkg::S_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= boxsum_pkg::S_IDLE;
      col   <= '0;
      row   <= '0;
    end else begin
      state <= state_nxt;
      if (clr) begin
        col <= COL_W'(1);
      end else if (pop) begin
        col <= col + 1'b1;
      end
      if (state == boxsum_pkg::S_IDLE) begin
        row <= '0;
      end else if (pop && col_last) begin
        row <= row + 1'b1;
      end
    end
  end

endmodule

/* rtl/sum_drain.sv */
`timescale 1ns/1ps

module sum_drain #(
  parameter int LANES     = 4,
  parameter int OUT_DEPTH = 4
) (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               wr,
  input  logic [LANES*boxsum_pkg::SUM_W-1:0] wr_data,
  input  logic                               inflight,
  input  logic                               out_credit,
  output logic                               out_valid,
  output logic [LANES*boxsum_pkg::SUM_W-1:0] out_data,
  output logic                               room
);

  localparam int DATA_W = LANES * boxsum_pkg::SUM_W;
  localparam int PTR_W  = (OUT_DEPTH > 1) ? $clog2(OUT_DEPTH) : 1;
  localparam int CNT_W  = $clog2(OUT_DEPTH + 1);
  // receiver may run ahead with credits; counter saturates
  localparam int CRED_W = 16;

  logic [DATA_W-1:0] mem [OUT_DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  count;
  logic [CRED_W-1:0] credits;
  logic              send;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(OUT_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign send = (count != '0) && (credits != '0);

  // the beat sitting in the lane register is not yet counted
  assign room = (int'(count) + int'(inflight)) < OUT_DEPTH;

  always_ff @(posedge clk) begin
    if (wr) begin
      mem[wr_ptr] <= wr_data;
    end
    if (send) begin
      out_data <= mem[rd_ptr];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      credits   <= '0;
      out_valid <= 1'b0;
    end else begin
      out_valid <= send;
      if (wr) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (send) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({wr, send})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      if (out_credit && !send && (credits != '1)) begin
        credits <= credits + 1'b1;
      end else if (send && !out_credit) begin
        credits <= credits - 1'b1;
      end
    end
  end

endmodule

/* rtl/boxsum_top.sv */
`timescale 1ns/1ps

module boxsum_top #(
  parameter int LANES      = 4,
  parameter int COLS       = 12,
  parameter int ROWS       = 3,
  parameter int FEED_DEPTH = 4,
  parameter int OUT_DEPTH  = 4
) (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                start,
  input  logic                                in_valid,
  input  logic [LANES*boxsum_pkg::PIX_W-1:0]  in_data,
  output logic                                in_credit,
  output logic                                out_valid,
  output logic [LANES*boxsum_pkg::SUM_W-1:0]  out_data,
  input  logic                                out_credit,
  output logic                                busy,
  output logic                                frame_done
);

  localparam int PIX_W = boxsum_pkg::PIX_W;
  localparam int SUM_W = boxsum_pkg::SUM_W;
  localparam int LVL_W = $clog2(FEED_DEPTH + 1);

  logic [LVL_W-1:0]       feed_level;
  logic [LANES*PIX_W-1:0] head_data;
  logic [LANES*SUM_W-1:0] lane_sum;
  logic [LANES-1:0]       lane_valid;
  logic                   pop;
  logic                   clr;
  logic                   shift;
  logic                   emit;
  logic                   room;

  beat_feeder #(
    .LANES      (LANES),
    .FEED_DEPTH (FEED_DEPTH)
  ) u_feeder (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .in_data    (in_data),
    .pop        (pop),
    .head_data  (head_data),
    .feed_level (feed_level),
    .in_credit  (in_credit)
  );

  row_ctrl #(
    .COLS  (COLS),
    .ROWS  (ROWS),
    .LVL_W (LVL_W)
  ) u_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (start),
    .feed_level (feed_level),
    .room       (room),
    .pop        (pop),
    .clr        (clr),
    .shift      (shift),
    .emit       (emit),
    .busy       (busy),
    .frame_done (frame_done)
  );

  for (genvar i = 0; i < LANES; i++) begin : g_lane
    window_lane u_lane (
      .clk       (clk),
      .rst_n     (rst_n),
      .pix       (head_data[i*PIX_W +: PIX_W]),
      .shift     (shift),
      .clr       (clr),
      .emit      (emit),
      .sum       (lane_sum[i*SUM_W +: SUM_W]),
      .sum_valid (lane_valid[i])
    );
  end

  // lane 0 valid is last cycle's emit, so it doubles as the in-flight reservation
  sum_drain #(
    .LANES     (LANES),
    .OUT_DEPTH (OUT_DEPTH)
  ) u_drain (
    .clk        (clk),
    .rst_n      (rst_n),
    .wr         (lane_valid[0]),
    .wr_data    (lane_sum),
    .inflight   (lane_valid[0]),
    .out_credit (out_credit),
    .out_valid  (out_valid),
    .out_data   (out_data),
    .room       (room)
  );

endmodule

/* test/boxsum_checker.sv */
`timescale 1ns/1ps

module boxsum_checker #(
  parameter int LANES = 4,
  parameter int COLS  = 12,
  parameter int ROWS  = 3
) (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               in_valid,
  input  logic [LANES*boxsum_pkg::PIX_W-1:0] in_data,
  input  logic                               out_valid,
  input  logic [LANES*boxsum_pkg::SUM_W-1:0] out_data,
  input  logic                               out_credit,
  input  logic                               frame_done,
  output int                                 errors,
  output int                                 out_beats,
  output int                                 frames
);

  localparam int PIX_W = boxsum_pkg::PIX_W;
  localparam int SUM_W = boxsum_pkg::SUM_W;
  localparam int WIN   = boxsum_pkg::WIN;

  // expected sums held at 16 bits per lane, wider than the DUT sum
  logic [PIX_W-1:0]    row_pix [LANES][COLS];
  logic [LANES*16-1:0] exp_q [$];
  int                  in_beats;
  int                  frame_start;
  int                  credits_seen;

  always @(posedge clk or negedge rst_n) begin : watch
    int col;
    int acc;
    int got;
    logic [LANES*16-1:0] beat;
    if (!rst_n) begin
      errors       = 0;
      out_beats    = 0;
      frames       = 0;
      in_beats     = 0;
      frame_start  = 0;
      credits_seen = 0;
      exp_q.delete();
    end else begin
      if (out_credit) begin
        credits_seen++;
      end
      if (in_valid) begin
        col = in_beats % COLS;
        for (int l = 0; l < LANES; l++) begin
          row_pix[l][col] = in_data[l*PIX_W +: PIX_W];
        end
        // a full window exists from the eighth pixel of the row on
        if (col >= WIN - 1) begin
          for (int l = 0; l < LANES; l++) begin
            acc = 0;
            for (int k = col - WIN + 1; k <= col; k++) begin
              acc = acc + int'(row_pix[l][k]);
            end
            beat[l*16 +: 16] = 16'(acc);
          end
          exp_q.push_back(beat);
        end
        in_beats++;
      end
      if (out_valid) begin
        out_beats++;
        if (out_beats > credits_seen) begin
          errors++;
          $display("output beat %0d at %0d ns was sent without an output credit",
                   out_beats, $time);
        end
        if (exp_q.size() == 0) begin
          errors++;
          $display("output beat at %0d ns arrived with no window sum expected", $time);
        end else begin
          beat = exp_q.pop_front();
          for (int l = 0; l < LANES; l++) begin
            got = int'(out_data[l*SUM_W +: SUM_W]);
            if (got != int'(beat[l*16 +: 16])) begin
              errors++;
              $display("Error: %0d ns lane %0d sum %0d, expected %0d",
                       $time, l, got, int'(beat[l*16 +: 16]));
            end
          end
        end
      end
      if (frame_done) begin
        frames++;
        if (in_beats - frame_start != ROWS * COLS) begin
          errors++;
          $display("frame_done at %0d ns came after %0d input beats instead of %0d",
                   $time, in_beats - frame_start, ROWS * COLS);
        end
        frame_start = in_beats;
      end
    end
  end

endmodule

/* test/boxsum_assertions.sv */
`timescale 1ns/1ps

module boxsum_assertions (
  input logic       clk,
  input logic       rst_n,
  input logic [2:0] state,
  input logic       pop,
  input logic       feed_nz,
  input logic       out_valid,
  input logic       out_credit
);

  // receiver credits not yet used up by an output beat
  int unspent;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      unspent <= 0;
    end else begin
      unspent <= unspent + int'(out_credit) - int'(out_valid);
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n) out_valid |-> unspent > 0)
    else $error("out_valid with no output credit held");

  assert property (@(posedge clk) disable iff (!rst_n) pop |-> feed_nz)
    else $error("pop while the feeder is empty");

  assert property (@(posedge clk) disable iff (!rst_n)
    state inside {boxsum_pkg::S_IDLE, boxsum_pkg::S_START, boxsum_pkg::S_ROW,
                  boxsum_pkg::S_FILL, boxsum_pkg::S_SLIDE, boxsum_pkg::S_FINISH})
    else $error("row sequencer state out of range");

endmodule

bind row_ctrl boxsum_assertions ctrl_rules (
  .clk(clk), .rst_n(rst_n), .state(state), .pop(pop), .feed_nz(feed_level != '0),
  .out_valid(1'b0), .out_credit(1'b0)
);

bind sum_drain boxsum_assertions drain_rules (
  .clk(clk), .rst_n(rst_n), .state(3'd0), .pop(1'b0), .feed_nz(1'b1),
  .out_valid(out_valid), .out_credit(out_credit)
);

/* test/boxsum_tb.sv */
`timescale 1ns/1ps

module boxsum_tb;

  localparam int LANES       = 4;
  localparam int COLS        = 12;
  localparam int ROWS        = 3;
  localparam int FEED_DEPTH  = 4;
  localparam int OUT_DEPTH   = 4;
  localparam int PIX_W       = boxsum_pkg::PIX_W;
  localparam int SUM_W       = boxsum_pkg::SUM_W;
  localparam int FRAME_BEATS = ROWS * COLS;
  localparam int EXP_BEATS   = ROWS * (COLS - 7);
  localparam int NUM_TESTS   = 5;
  localparam int MODE_RAMP   = 0;
  localparam int MODE_CONST  = 1;
  localparam int MODE_LFSR   = 2;
  // negative input gap means a random gap of 0 to 3 cycles
  localparam int RAND_GAP    = -1;
  localparam int MAX_RAND    = 3;

  logic                   clk;
  logic                   rst_n;
  logic                   start;
  logic                   in_valid;
  logic [LANES*PIX_W-1:0] in_data;
  logic                   in_credit;
  logic                   out_valid;
  logic [LANES*SUM_W-1:0] out_data;
  logic                   out_credit;
  logic                   busy;
  logic                   frame_done;

  int test_mode [NUM_TESTS]   = '{MODE_RAMP, MODE_CONST, MODE_LFSR, MODE_RAMP, MODE_LFSR};
  int test_in_gap [NUM_TESTS] = '{0, 1, RAND_GAP, 0, 2};
  int test_cr_gap [NUM_TESTS] = '{0, 0, 1, 6, 3};
  int test_expect [NUM_TESTS] = '{EXP_BEATS, EXP_BEATS, EXP_BEATS, EXP_BEATS, EXP_BEATS};

  logic [31:0] lfsr_state;
  int          credits_back = 0;
  int          beats_sent   = 0;
  int          cycles       = 0;
  int          cycle_limit  = 0;
  bit          verdict_printed = 1'b0;
  int          chk_errors;
  int          chk_out_beats;
  int          chk_frames;

  boxsum_top #(
    .LANES(LANES), .COLS(COLS), .ROWS(ROWS), .FEED_DEPTH(FEED_DEPTH), .OUT_DEPTH(OUT_DEPTH)
  ) UUT (
    .clk(clk), .rst_n(rst_n), .start(start), .in_valid(in_valid), .in_data(in_data),
    .in_credit(in_credit), .out_valid(out_valid), .out_data(out_data),
    .out_credit(out_credit), .busy(busy), .frame_done(frame_done)
  );

  boxsum_checker #(.LANES(LANES), .COLS(COLS), .ROWS(ROWS)) u_checker (
    .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .in_data(in_data),
    .out_valid(out_valid), .out_data(out_data), .out_credit(out_credit),
    .frame_done(frame_done), .errors(chk_errors), .out_beats(chk_out_beats),
    .frames(chk_frames)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    if (in_credit) begin
      credits_back++;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      verdict_printed = 1'b1;
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("TESTS FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  function automatic int take_bits(input int n);
    int v;
    int i;
    v = 0;
    for (i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = v | (int'(lfsr_state[0]) << i);
    end
    return v;
  endfunction

  function automatic logic [LANES*PIX_W-1:0] pixel_beat(input int mode, input int test,
                                                        input int beat);
    logic [LANES*PIX_W-1:0] data;
    int l;
    for (l = 0; l < LANES; l++) begin
      case (mode)
        MODE_RAMP:  data[l*PIX_W +: PIX_W] = PIX_W'(beat * 5 + l * 37 + test * 11);
        MODE_CONST: data[l*PIX_W +: PIX_W] = '1;
        default:    data[l*PIX_W +: PIX_W] = PIX_W'(take_bits(PIX_W));
      endcase
    end
    return data;
  endfunction

  function automatic int timeout_limit();
    int total;
    int g;
    int i;
    total = 16;
    for (i = 0; i < NUM_TESTS; i++) begin
      g = (test_in_gap[i] < 0) ? MAX_RAND : test_in_gap[i];
      if (test_cr_gap[i] > g) begin
        g = test_cr_gap[i];
      end
      total = total + FRAME_BEATS * (g + 1) * 4;
    end
    return total;
  endfunction

  // called and left at 1 ns after a rising edge
  task automatic send_frame(input int mode, input int test, input int gap);
    int b;
    int g;
    for (b = 0; b < FRAME_BEATS; b++) begin
      while (FEED_DEPTH + credits_back - beats_sent <= 0) begin
        @(posedge clk);
        #1;
      end
      in_data  = pixel_beat(mode, test, b);
      in_valid = 1'b1;
      beats_sent++;
      @(posedge clk);
      #1;
      in_valid = 1'b0;
      g = (gap < 0) ? take_bits(2) : gap;
      repeat (g) begin
        @(posedge clk);
        #1;
      end
    end
  endtask

  task automatic give_credits(input int count, input int gap);
    repeat (count) begin
      out_credit = 1'b1;
      @(posedge clk);
      #1;
      out_credit = 1'b0;
      repeat (gap) begin
        @(posedge clk);
        #1;
      end
    end
  endtask

  initial begin
    int t;
    int fails;
    int test_errs;
    int base_err;
    int base_out;
    int base_frames;
    rst_n       = 1'b0;
    start       = 1'b0;
    in_valid    = 1'b0;
    in_data     = '0;
    out_credit  = 1'b0;
    lfsr_state  = 32'hd5575d9f;
    cycle_limit = timeout_limit();
    fails       = 0;
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(posedge clk);
    #1;
    for (t = 0; t < NUM_TESTS; t++) begin
      base_err    = chk_errors;
      base_out    = chk_out_beats;
      base_frames = chk_frames;
      start = 1'b1;
      @(posedge clk);
      #1;
      start = 1'b0;
      // one spare credit so that an extra beat can get out
      fork
        send_frame(test_mode[t], t, test_in_gap[t]);
        give_credits(test_expect[t] + 1, test_cr_gap[t]);
      join
      while (chk_frames == base_frames || chk_out_beats - base_out < test_expect[t]) begin
        @(posedge clk);
        #1;
      end
      // room for a stray extra beat or late credit to show
      repeat (OUT_DEPTH + 4) begin
        @(posedge clk);
        #1;
      end
      test_errs = chk_errors - base_err;
      if (chk_out_beats - base_out != test_expect[t]) begin
        test_errs++;
        $display("test %0d gave %0d output beats instead of %0d",
                 t, chk_out_beats - base_out, test_expect[t]);
      end
      if (credits_back != beats_sent) begin
        test_errs++;
        $display("test %0d: %0d input credits came back for %0d beats sent",
                 t, credits_back, beats_sent);
      end
      if (busy) begin
        test_errs++;
        $display("test %0d: busy still high after frame_done", t);
      end
      if (test_errs != 0) begin
        fails++;
      end
      $display("test %0d mode %0d: %0d beats, %0d errors",
               t, test_mode[t], chk_out_beats - base_out, test_errs);
    end
    verdict_printed = 1'b1;
    $display("%0d tests run, %0d failed, %0d checker errors", NUM_TESTS, fails, chk_errors);
    if (fails == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  // a run stopped by a failing assertion never reaches the summary
  final begin
    if (!verdict_printed) begin
      $display("TESTS FAILED");
    end
  end

endmodule

/* flist.f */
common/boxsum_pkg.sv
lane/window_lane.sv
rtl/beat_feeder.sv
rtl/row_ctrl.sv
rtl/sum_drain.sv
rtl/boxsum_top.sv
test/boxsum_checker.sv
test/boxsum_assertions.sv
test/boxsum_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module boxsum_tb \
  -Mdir obj_dir -o boxsum_sim

./obj_dir/boxsum_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTS PASSED" sim.log; then
  exit 0
else
  exit 1
fi
